// ==== source/risk_pkg.sv ====
package risk_pkg;

  // order fields
  typedef logic [15:0] price_t;     // price in ticks
  typedef logic [15:0] qty_t;       // quantity in lots
  typedef logic [31:0] notional_t;  // price times quantity, also the notional limit type

  // bookkeeping
  typedef logic [15:0] count_t;     // event counter, wraps at the top

  // apb bus
  typedef logic [7:0]  apb_addr_t;  // byte address
  typedef logic [31:0] apb_data_t;  // data word

  // register map
  localparam apb_addr_t ADDR_MAX_QTY      = 8'h00;  // staged max quantity, rw
  localparam apb_addr_t ADDR_MAX_NOTIONAL = 8'h04;  // staged max notional, rw
  localparam apb_addr_t ADDR_REJECT_COUNT = 8'h08;  // rejected orders, ro
  localparam apb_addr_t ADDR_SENT_COUNT   = 8'h0C;  // delivered orders, ro

  // order sequencer states
  typedef enum logic [1:0] {
    st_idle    = 2'd0,  // waiting for an order or a limit update
    st_check   = 2'd1,  // held order is judged by the risk checker
    st_send    = 2'd2,  // held order offered downstream
    st_new_max = 2'd3   // staged limits committed to the checker
  } seq_state_t;

endpackage

// ==== source/limit_regs.sv ====
`timescale 1ns/1ps

module limit_regs (
  input  logic                clk,
  input  logic                reset,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  risk_pkg::apb_addr_t paddr,
  input  risk_pkg::apb_data_t pwdata,
  input  logic                update_max,    // sequencer commits staged limits
  input  logic                reject_pulse,  // one order dropped
  input  logic                sent_pulse,    // one order delivered
  output risk_pkg::apb_data_t prdata,
  output logic                pready,
  output logic                pslverr,
  output risk_pkg::qty_t      staged_max_qty,
  output risk_pkg::notional_t staged_max_notional,
  output logic                new_max        // staged limits wait for commit
);

  logic             access;        // apb access phase
  logic             sel_qty;
  logic             sel_notional;
  logic             sel_reject;
  logic             sel_sent;
  logic             addr_hit;      // one of the four registers
  logic             count_hit;     // read-only counter register
  logic             limit_wr;      // accepted write to a limit
  risk_pkg::count_t reject_count;
  risk_pkg::count_t sent_count;

  assign access       = psel & penable;
  assign sel_qty      = (paddr == risk_pkg::ADDR_MAX_QTY);
  assign sel_notional = (paddr == risk_pkg::ADDR_MAX_NOTIONAL);
  assign sel_reject   = (paddr == risk_pkg::ADDR_REJECT_COUNT);
  assign sel_sent     = (paddr == risk_pkg::ADDR_SENT_COUNT);
  assign addr_hit     = sel_qty | sel_notional | sel_reject | sel_sent;
  assign count_hit    = sel_reject | sel_sent;
  assign limit_wr     = access & pwrite & (sel_qty | sel_notional);

  assign pready  = 1'b1;                                   // zero wait states
  assign pslverr = access & (~addr_hit | (pwrite & count_hit)); // unmapped or ro write

  // read mux, only live in the access phase
  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      if (sel_qty) begin
        prdata = {16'h0000, staged_max_qty};     // staged, not active
      end else if (sel_notional) begin
        prdata = staged_max_notional;
      end else if (sel_reject) begin
        prdata = {16'h0000, reject_count};
      end else if (sel_sent) begin
        prdata = {16'h0000, sent_count};
      end
    end
  end

  // staged limits, open at reset so every order passes
  always_ff @(posedge clk) begin
    if (reset) begin
      staged_max_qty      <= '1;
      staged_max_notional <= '1;
    end else if (limit_wr) begin
      if (sel_qty) staged_max_qty <= pwdata[15:0];
      if (sel_notional) staged_max_notional <= pwdata;
    end
  end

  // pending flag, a fresh write wins over a commit on the same edge
  always_ff @(posedge clk) begin
    if (reset) begin
      new_max <= 1'b0;
    end else if (limit_wr) begin
      new_max <= 1'b1;                 // commit again to pick up this value
    end else if (update_max) begin
      new_max <= 1'b0;
    end
  end

  // event counters
  always_ff @(posedge clk) begin
    if (reset) begin
      reject_count <= '0;
      sent_count   <= '0;
    end else begin
      if (reject_pulse) reject_count <= reject_count + 1'b1; // wraps
      if (sent_pulse) sent_count <= sent_count + 1'b1;
    end
  end

endmodule

// ==== source/risk_checker.sv ====
`timescale 1ns/1ps

module risk_checker (
  input  logic                clk,
  input  logic                reset,
  input  logic                update_max,           // load staged limits
  input  risk_pkg::qty_t      staged_max_qty,
  input  risk_pkg::notional_t staged_max_notional,
  input  risk_pkg::price_t    held_price,           // order under check
  input  risk_pkg::qty_t      held_qty,
  output logic                risk_ok               // 1 = order passes
);

  risk_pkg::qty_t      active_max_qty;
  risk_pkg::notional_t active_max_notional;
  risk_pkg::notional_t held_notional;   // price times quantity
  logic                qty_ok;
  logic                notional_ok;

  // active limits only move on a commit
  // the sequencer never commits during a check
  always_ff @(posedge clk) begin
    if (reset) begin
      active_max_qty      <= '1;          // fully open
      active_max_notional <= '1;
    end else if (update_max) begin
      active_max_qty      <= staged_max_qty;
      active_max_notional <= staged_max_notional;
    end
  end

  // 16x16 product fits the 32 bit notional exactly
  assign held_notional = risk_pkg::notional_t'(held_price) *
                         risk_pkg::notional_t'(held_qty);

  assign qty_ok      = (held_qty <= active_max_qty);           // equal passes
  assign notional_ok = (held_notional <= active_max_notional);

  assign risk_ok = qty_ok & notional_ok;  // both limits must hold

endmodule

// ==== source/order_sequencer.sv ====
`timescale 1ns/1ps

module order_sequencer (
  input  logic             clk,
  input  logic             reset,
  input  logic             order_valid,
  input  risk_pkg::price_t order_price,
  input  risk_pkg::qty_t   order_qty,
  input  logic             risk_ok,       // verdict for the held order
  input  logic             new_max,       // staged limits pending
  input  logic             out_ready,     // downstream acknowledge
  output logic             order_ready,
  output risk_pkg::price_t held_price,
  output risk_pkg::qty_t   held_qty,
  output logic             out_valid,
  output logic             update_max,
  output logic             reject_pulse,
  output logic             sent_pulse
);

  risk_pkg::seq_state_t state;
  logic                 accept;     // order handshake on this edge

  // only idle takes orders, and a pending update blocks them
  assign order_ready = (state == risk_pkg::st_idle) && !new_max;
  assign accept      = order_valid & order_ready;

  assign out_valid  = (state == risk_pkg::st_send);    // held order offered
  assign update_max = (state == risk_pkg::st_new_max); // checker loads limits

  // single order buffer
  always_ff @(posedge clk) begin
    if (accept) begin
      held_price <= order_price;
      held_qty   <= order_qty;       // stable until back in idle
    end
  end

  // state machine
  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= risk_pkg::st_idle;
      reject_pulse <= 1'b0;
      sent_pulse   <= 1'b0;
    end else begin
      reject_pulse <= 1'b0;          // pulses last one cycle
      sent_pulse   <= 1'b0;
      case (state)
        risk_pkg::st_idle: begin
          if (new_max) begin
            state <= risk_pkg::st_new_max;   // limit update first
          end else if (accept) begin
            state <= risk_pkg::st_check;
          end
        end

        risk_pkg::st_check: begin
          // one cycle, checker is combinational on the held order
          if (risk_ok) begin
            state <= risk_pkg::st_send;
          end else begin
            reject_pulse <= 1'b1;            // order dropped
            state        <= risk_pkg::st_idle;
          end
        end

        risk_pkg::st_send: begin
          if (out_ready) begin
            sent_pulse <= 1'b1;              // delivered
            state      <= risk_pkg::st_idle;
          end
        end

        risk_pkg::st_new_max: begin
          state <= risk_pkg::st_idle;        // commit takes one cycle
        end

        default: begin
          state <= risk_pkg::st_idle;
        end
      endcase
    end
  end

endmodule

// ==== source/order_gateway.sv ====
`timescale 1ns/1ps

module order_gateway (
  input  logic                clk,
  input  logic                reset,
  // apb configuration port
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  risk_pkg::apb_addr_t paddr,
  input  risk_pkg::apb_data_t pwdata,
  output risk_pkg::apb_data_t prdata,
  output logic                pready,
  output logic                pslverr,
  // order in
  input  logic                order_valid,
  output logic                order_ready,
  input  risk_pkg::price_t    order_price,
  input  risk_pkg::qty_t      order_qty,
  // order out
  output logic                out_valid,
  input  logic                out_ready,
  output risk_pkg::price_t    out_price,
  output risk_pkg::qty_t      out_qty
);

  risk_pkg::qty_t      staged_max_qty;
  risk_pkg::notional_t staged_max_notional;
  logic                new_max;        // regs to sequencer
  logic                update_max;     // sequencer to regs and checker
  logic                reject_pulse;
  logic                sent_pulse;
  logic                risk_ok;        // checker to sequencer
  risk_pkg::price_t    held_price;
  risk_pkg::qty_t      held_qty;

  // held order goes straight out
  assign out_price = held_price;
  assign out_qty   = held_qty;

  limit_regs i_limit_regs (
    .clk                 (clk),
    .reset               (reset),
    .psel                (psel),
    .penable             (penable),
    .pwrite              (pwrite),
    .paddr               (paddr),
    .pwdata              (pwdata),
    .update_max          (update_max),
    .reject_pulse        (reject_pulse),
    .sent_pulse          (sent_pulse),
    .prdata              (prdata),
    .pready              (pready),
    .pslverr             (pslverr),
    .staged_max_qty      (staged_max_qty),
    .staged_max_notional (staged_max_notional),
    .new_max             (new_max)
  );

  risk_checker i_risk_checker (
    .clk                 (clk),
    .reset               (reset),
    .update_max          (update_max),
    .staged_max_qty      (staged_max_qty),
    .staged_max_notional (staged_max_notional),
    .held_price          (held_price),
    .held_qty            (held_qty),
    .risk_ok             (risk_ok)
  );

  order_sequencer i_order_sequencer (
    .clk          (clk),
    .reset        (reset),
    .order_valid  (order_valid),
    .order_price  (order_price),
    .order_qty    (order_qty),
    .risk_ok      (risk_ok),
    .new_max      (new_max),
    .out_ready    (out_ready),
    .order_ready  (order_ready),
    .held_price   (held_price),
    .held_qty     (held_qty),
    .out_valid    (out_valid),
    .update_max   (update_max),
    .reject_pulse (reject_pulse),
    .sent_pulse   (sent_pulse)
  );

endmodule

// ==== test/tb_order_gateway.sv ====
`timescale 1ns/1ps

module tb_order_gateway;

  localparam int K_WRITE = 0;  // apb write row
  localparam int K_READ  = 1;  // apb read row
  localparam int K_ORDER = 2;  // order row
  localparam int TIMEOUT = 40; // cycles allowed per wait

  logic                clk;
  logic                reset;
  logic                psel;
  logic                penable;
  logic                pwrite;
  risk_pkg::apb_addr_t paddr;
  risk_pkg::apb_data_t pwdata;
  risk_pkg::apb_data_t prdata;
  logic                pready;
  logic                pslverr;
  logic                order_valid;
  logic                order_ready;
  risk_pkg::price_t    order_price;
  risk_pkg::qty_t      order_qty;
  logic                out_valid;
  logic                out_ready;
  risk_pkg::price_t    out_price;
  risk_pkg::qty_t      out_qty;

  integer              seed;          // $random state
  int                  checks;
  int                  errors;
  int                  timeouts;
  risk_pkg::qty_t      max_qty;       // reference copy of the limits
  risk_pkg::notional_t max_notional;
  risk_pkg::count_t    exp_reject;
  risk_pkg::count_t    exp_sent;
  int                  step_kind[$];  // stimulus table columns
  logic [31:0]         step_a[$];     // address or price
  logic [31:0]         step_b[$];     // write data or quantity
  logic                step_stall[$]; // random out_ready for this order
  risk_pkg::apb_addr_t addr;
  risk_pkg::apb_data_t rdata;
  risk_pkg::apb_data_t exp_data;
  risk_pkg::notional_t notional;
  logic                exp_err;
  logic                exp_pass;

  order_gateway i_order_gateway (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .order_valid(order_valid), .order_ready(order_ready), .order_price(order_price),
    .order_qty(order_qty), .out_valid(out_valid), .out_ready(out_ready),
    .out_price(out_price), .out_qty(out_qty)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  task automatic add_step(input int kind, input logic [31:0] a, input logic [31:0] b,
                          input logic stall);
    step_kind.push_back(kind);
    step_a.push_back(a);
    step_b.push_back(b);
    step_stall.push_back(stall);
  endtask

  task automatic check_order(input risk_pkg::price_t exp_price, input risk_pkg::qty_t exp_qty);
    checks++;
    if (out_price !== exp_price || out_qty !== exp_qty) begin
      errors++;
      $display("** Error at %0t: order out %0d x %0d, expected %0d x %0d",
               $time, out_price, out_qty, exp_price, exp_qty);
    end
  endtask

  task automatic check_count(input risk_pkg::count_t got, input risk_pkg::count_t exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input risk_pkg::apb_data_t got, input risk_pkg::apb_data_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // one zero-wait apb transfer with read data sampled in the access phase
  task automatic apb_xfer(input logic write, input risk_pkg::apb_addr_t a,
                          input risk_pkg::apb_data_t wdata, input logic err,
                          output risk_pkg::apb_data_t data);
    @(negedge clk);
    psel    = 1'b1;  // setup phase
    penable = 1'b0;
    pwrite  = write;
    paddr   = a;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;  // access phase
    #10;             // comb read path settles
    data = prdata;
    check_flag(pready, 1'b1, "pready");
    check_flag(pslverr, err, "pslverr");
    @(negedge clk);  // transfer done on the edge before this
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic send_order(input risk_pkg::price_t price, input risk_pkg::qty_t qty,
                            input logic stall, input logic pass);
    int   n;
    logic done;
    @(negedge clk);
    order_valid = 1'b1;
    order_price = price;
    order_qty   = qty;
    out_ready   = !stall;  // stalled orders see at least one cycle of back-pressure
    n = 0;
    while (!order_ready && n < TIMEOUT) begin  // blocked while a limit commits
      @(negedge clk);
      n++;
    end
    if (!order_ready) begin
      timeouts++;
      $display("order_ready never came back, order %0d x %0d was not taken", price, qty);
      order_valid = 1'b0;
      return;
    end
    @(negedge clk);  // acceptance edge is behind us
    order_valid = 1'b0;
    check_flag(out_valid, 1'b0, "out_valid during the check");
    @(negedge clk);  // two edges after acceptance
    if (!pass) begin
      check_flag(out_valid, 1'b0, "out_valid on a rejected order");
      check_flag(order_ready, 1'b1, "order_ready after a reject");
      exp_reject++;
      return;
    end
    check_flag(out_valid, 1'b1, "out_valid two edges after acceptance");
    n    = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      if (out_valid) begin
        check_order(price, qty);  // held stable through stalls
        done = out_ready;         // handshake on the coming edge
      end
      @(negedge clk);
      n++;
      if (stall && !done) out_ready = 1'(($random(seed) & 3) != 0);
    end
    if (!done) begin
      timeouts++;
      $display("order %0d x %0d was never delivered", price, qty);
      return;
    end
    check_flag(out_valid, 1'b0, "out_valid after delivery");  // no duplicate
    exp_sent++;
  endtask

  initial begin
    seed        = 32'h7e50;
    checks      = 0;
    errors      = 0;
    timeouts    = 0;
    reset       = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    order_valid = 1'b0;
    order_price = '0;
    order_qty   = '0;
    out_ready   = 1'b1;
    max_qty      = '1;  // limits open after reset
    max_notional = '1;
    exp_reject   = '0;
    exp_sent     = '0;

    add_step(K_READ, risk_pkg::ADDR_REJECT_COUNT, 0, 0);  // counters start at 0
    add_step(K_READ, risk_pkg::ADDR_SENT_COUNT, 0, 0);
    add_step(K_READ, risk_pkg::ADDR_MAX_QTY, 0, 0);
    add_step(K_ORDER, 16'hFFFF, 16'hFFFF, 0);             // largest order passes
    add_step(K_ORDER, 100, 10, 0);
    add_step(K_WRITE, risk_pkg::ADDR_MAX_QTY, 50, 0);
    add_step(K_READ, risk_pkg::ADDR_MAX_QTY, 0, 0);
    add_step(K_ORDER, 10, 50, 0);                         // qty exactly at limit
    add_step(K_ORDER, 10, 51, 0);
    add_step(K_WRITE, risk_pkg::ADDR_MAX_NOTIONAL, 1000, 0);
    add_step(K_READ, risk_pkg::ADDR_MAX_NOTIONAL, 0, 0);
    add_step(K_ORDER, 20, 50, 0);                         // notional exactly at limit
    add_step(K_ORDER, 21, 48, 0);                         // qty within limit but notional over
    add_step(K_ORDER, 1001, 1, 0);
    add_step(K_WRITE, risk_pkg::ADDR_REJECT_COUNT, 5, 0); // read-only so the count is kept
    add_step(K_READ, risk_pkg::ADDR_REJECT_COUNT, 0, 0);
    add_step(K_READ, 8'h10, 0, 0);                        // unmapped
    add_step(K_WRITE, 8'h14, 32'hDEAD, 0);
    add_step(K_ORDER, 5, 5, 1);                           // random back-pressure
    add_step(K_ORDER, 7, 30, 1);
    add_step(K_ORDER, 3, 40, 1);
    add_step(K_ORDER, 9, 60, 1);
    add_step(K_ORDER, 2, 45, 1);
    add_step(K_WRITE, risk_pkg::ADDR_MAX_QTY, 32'h1234FFFF, 0);  // upper bits dropped
    add_step(K_WRITE, risk_pkg::ADDR_MAX_NOTIONAL, 32'hFFFFFFFF, 0);
    add_step(K_ORDER, 1000, 1000, 1);
    add_step(K_READ, risk_pkg::ADDR_SENT_COUNT, 0, 0);    // final totals
    add_step(K_READ, risk_pkg::ADDR_REJECT_COUNT, 0, 0);

    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_flag(order_ready, 1'b1, "order_ready after reset");
    check_flag(out_valid, 1'b0, "out_valid after reset");
    check_flag(pslverr, 1'b0, "pslverr after reset");

    for (int i = 0; i < step_kind.size(); i++) begin
      addr = step_a[i][7:0];
      case (step_kind[i])
        K_WRITE: begin
          exp_err = !(addr == risk_pkg::ADDR_MAX_QTY || addr == risk_pkg::ADDR_MAX_NOTIONAL);
          apb_xfer(1'b1, addr, step_b[i], exp_err, rdata);
          if (addr == risk_pkg::ADDR_MAX_QTY) max_qty = step_b[i][15:0];
          if (addr == risk_pkg::ADDR_MAX_NOTIONAL) max_notional = step_b[i];
        end
        K_READ: begin
          exp_err = 1'b0;
          case (addr)
            risk_pkg::ADDR_MAX_QTY:      exp_data = {16'h0000, max_qty};
            risk_pkg::ADDR_MAX_NOTIONAL: exp_data = max_notional;
            risk_pkg::ADDR_REJECT_COUNT: exp_data = {16'h0000, exp_reject};
            risk_pkg::ADDR_SENT_COUNT:   exp_data = {16'h0000, exp_sent};
            default: begin
              exp_err  = 1'b1;  // unmapped reads zero with an error
              exp_data = '0;
            end
          endcase
          apb_xfer(1'b0, addr, '0, exp_err, rdata);
          if (addr == risk_pkg::ADDR_REJECT_COUNT || addr == risk_pkg::ADDR_SENT_COUNT) begin
            check_count(rdata[15:0], exp_data[15:0], "counter read");
          end else begin
            check_data(rdata, exp_data, "register read");
          end
        end
        default: begin
          notional = {16'h0000, step_a[i][15:0]} * {16'h0000, step_b[i][15:0]};
          exp_pass = (step_b[i][15:0] <= max_qty) && (notional <= max_notional);
          send_order(step_a[i][15:0], step_b[i][15:0], step_stall[i], exp_pass);
        end
      endcase
    end

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
source/risk_pkg.sv
source/limit_regs.sv
source/risk_checker.sv
source/order_sequencer.sv
source/order_gateway.sv
test/tb_order_gateway.sv

// ==== Bender.yml ====
package:
  name: order_gateway

sources:
  - files:
      - source/risk_pkg.sv
      - source/limit_regs.sv
      - source/risk_checker.sv
      - source/order_sequencer.sv
      - source/order_gateway.sv
  - target: test
    files:
      - test/tb_order_gateway.sv
